//--- include/seq_settings.svh
`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// program address width, also the width of every ireg source
`define SEQ_ADDR_W 8

// op + dev + cmd + imm
`define SEQ_INST_W 20

// program words, one per address
`define SEQ_DEPTH 256

// command destinations on the bus, one wen bit each
`define SEQ_NUM_DEV 8

`endif

//--- logic/seq_pkg.sv
`include "seq_settings.svh"

package seq_pkg;

   // instruction opcodes, 9 to 15 are illegal
   typedef enum logic [3:0] {
      op_no = 4'd0,  // no operation
      op_ci = 4'd1,  // command with immediate
      op_cr = 4'd2,  // command with ireg value
      op_ji = 4'd3,  // jump to label
      op_jr = 4'd4,  // jump to ireg value
      op_jz = 4'd5,  // jump if ireg zero
      op_jn = 4'd6,  // jump if ireg non-zero
      op_wz = 4'd7,  // stall until ireg zero
      op_wn = 4'd8   // stall until ireg non-zero
   } seq_op_e;

   typedef enum logic [2:0] {
      st_reset  = 3'd0,
      st_ready  = 3'd1,
      st_wait_z = 3'd2,
      st_wait_n = 3'd3,
      st_error  = 3'd4
   } seq_state_e;

   // label for jumps is {dev, cmd}, src is imm[1:0]
   typedef struct packed {
      seq_op_e                op;
      logic [3:0]             dev;
      logic [3:0]             cmd;
      logic [`SEQ_ADDR_W-1:0] imm;
   } seq_inst_t;

   // command word on the device bus
   typedef struct packed {
      logic [3:0]             cmd;
      logic [`SEQ_ADDR_W-1:0] arg;
   } dev_cmd_t;

   typedef enum logic [3:0] {
      cnt_clear = 4'd0,
      cnt_load  = 4'd1,
      cnt_inc   = 4'd2,
      cnt_dec   = 4'd3
   } counter_cmd_e;

   typedef enum logic [3:0] {
      io_set = 4'd0,
      io_and = 4'd1,
      io_or  = 4'd2,
      io_xor = 4'd3
   } io_cmd_e;

endpackage

//--- logic/prog_mem.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module prog_mem (
   input  logic                   clock,
   input  logic                   reset,
   input  logic [`SEQ_ADDR_W-1:0] addr,
   output seq_pkg::seq_inst_t     inst,
   input  logic                   load_req,
   input  logic [`SEQ_ADDR_W-1:0] load_addr,
   input  seq_pkg::seq_inst_t     load_word,
   output logic                   load_ack
);
   import seq_pkg::*;

   seq_inst_t mem [`SEQ_DEPTH];
   logic      write_en;

   // first edge with req high and ack still low
   assign write_en = load_req && !load_ack;

   // fetch is combinational, the core reads inst in the cycle it drives next
   assign inst = mem[addr];

   always_ff @(posedge clock) begin
      if (write_en && !reset) begin
         mem[load_addr] <= load_word;
      end
   end

   // four-phase ack
   always_ff @(posedge clock) begin
      if (reset) begin
         load_ack <= 1'b0;
      end else if (write_en) begin
         load_ack <= 1'b1;
      end else if (!load_req) begin
         load_ack <= 1'b0;  // host has dropped req
      end
   end

endmodule

//--- logic/counter_dev.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module counter_dev (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   cmd_en,
   input  seq_pkg::dev_cmd_t      cmd,
   output logic [`SEQ_ADDR_W-1:0] count
);
   import seq_pkg::*;

   counter_cmd_e op;

   assign op = counter_cmd_e'(cmd.cmd);

   // inc and dec wrap around
   always_ff @(posedge clock) begin
      if (reset) begin
         count <= '0;
      end else if (cmd_en) begin
         case (op)
            cnt_clear: count <= '0;
            cnt_load:  count <= cmd.arg;
            cnt_inc:   count <= count + 1'b1;
            cnt_dec:   count <= count - 1'b1;
            default:   count <= count;  // unknown commands ignored
         endcase
      end
   end

endmodule

//--- logic/io_dev.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module io_dev (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   cmd_en,
   input  seq_pkg::dev_cmd_t      cmd,
   input  logic [`SEQ_ADDR_W-1:0] ext_in,
   output logic [`SEQ_ADDR_W-1:0] sync_in,
   output logic [`SEQ_ADDR_W-1:0] port_out
);
   import seq_pkg::*;

   io_cmd_e                op;
   logic [`SEQ_ADDR_W-1:0] sync_meta;  // first synchroniser stage

   assign op = io_cmd_e'(cmd.cmd);

   // port latch, bitwise ops with the argument
   always_ff @(posedge clock) begin
      if (reset) begin
         port_out <= '0;
      end else if (cmd_en) begin
         case (op)
            io_set:  port_out <= cmd.arg;
            io_and:  port_out <= port_out & cmd.arg;
            io_or:   port_out <= port_out | cmd.arg;
            io_xor:  port_out <= port_out ^ cmd.arg;
            default: port_out <= port_out;
         endcase
      end
   end

   // ext_in visible on sync_in two edges later
   always_ff @(posedge clock) begin
      if (reset) begin
         sync_meta <= '0;
         sync_in   <= '0;
      end else begin
         sync_meta <= ext_in;
         sync_in   <= sync_meta;
      end
   end

endmodule

//--- logic/seq_core.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module seq_core (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    run,
   input  seq_pkg::seq_inst_t      inst,
   input  logic [`SEQ_ADDR_W-1:0]  ireg_0,
   input  logic [`SEQ_ADDR_W-1:0]  ireg_1,
   input  logic [`SEQ_ADDR_W-1:0]  ireg_2,
   input  logic [`SEQ_ADDR_W-1:0]  ireg_3,
   output logic [`SEQ_ADDR_W-1:0]  next,
   output seq_pkg::dev_cmd_t       oreg,
   output logic [`SEQ_NUM_DEV-1:0] oreg_wen,
   output logic                    fault
);
   import seq_pkg::*;

   localparam int DEV_W = $clog2(`SEQ_NUM_DEV);

   seq_state_e              state;
   seq_state_e              state_nxt;
   logic [`SEQ_ADDR_W-1:0]  pc_nxt;
   logic [`SEQ_ADDR_W-1:0]  pc_inc;
   logic [`SEQ_ADDR_W-1:0]  label;
   logic [`SEQ_ADDR_W-1:0]  src_val;
   logic [1:0]              src;
   logic [DEV_W-1:0]        dst;
   logic [`SEQ_NUM_DEV-1:0] wen_dec;
   logic [`SEQ_NUM_DEV-1:0] wen_nxt;
   dev_cmd_t                oreg_nxt;

   assign label  = {inst.dev, inst.cmd};  // jump target spans dev and cmd
   assign src    = inst.imm[1:0];
   assign dst    = inst.dev[DEV_W-1:0];   // top bit of dev nibble unused
   assign pc_inc = next + 1'b1;

   // ireg select
   always_comb begin
      case (src)
         2'd0:    src_val = ireg_0;
         2'd1:    src_val = ireg_1;
         2'd2:    src_val = ireg_2;
         default: src_val = ireg_3;
      endcase
   end

   always_comb begin
      wen_dec      = '0;
      wen_dec[dst] = 1'b1;  // one-hot destination
   end

   // bus is idle unless a CI or CR executes
   always_comb begin
      state_nxt = state;
      pc_nxt    = next;
      oreg_nxt  = '0;
      wen_nxt   = '0;
      case (state)
         st_reset: begin
            state_nxt = st_ready;
            pc_nxt    = '0;
         end
         st_ready: begin
            if (run) begin
               case (inst.op)
                  op_no: pc_nxt = pc_inc;
                  op_ci: begin
                     pc_nxt       = pc_inc;
                     oreg_nxt.cmd = inst.cmd;
                     oreg_nxt.arg = inst.imm;
                     wen_nxt      = wen_dec;
                  end
                  op_cr: begin
                     pc_nxt       = pc_inc;
                     oreg_nxt.cmd = inst.cmd;
                     oreg_nxt.arg = src_val;
                     wen_nxt      = wen_dec;
                  end
                  op_ji: pc_nxt = label;
                  op_jr: pc_nxt = src_val;
                  op_jz: pc_nxt = (src_val == '0) ? label : pc_inc;
                  op_jn: pc_nxt = (src_val != '0) ? label : pc_inc;
                  op_wz: begin
                     if (src_val == '0) pc_nxt = pc_inc;
                     else state_nxt = st_wait_z;
                  end
                  op_wn: begin
                     if (src_val != '0) pc_nxt = pc_inc;
                     else state_nxt = st_wait_n;
                  end
                  default: begin  // illegal opcode
                     state_nxt = st_error;
                     pc_nxt    = '0;
                  end
               endcase
            end
         end
         // inst still holds the wait instruction, so src is the same ireg
         st_wait_z: begin
            if (run && src_val == '0) begin
               state_nxt = st_ready;
               pc_nxt    = pc_inc;
            end
         end
         st_wait_n: begin
            if (run && src_val != '0) begin
               state_nxt = st_ready;
               pc_nxt    = pc_inc;
            end
         end
         default: begin  // error is sticky until reset
            state_nxt = st_error;
            pc_nxt    = '0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= st_reset;
         next     <= '0;
         oreg     <= '0;
         oreg_wen <= '0;
      end else begin
         state    <= state_nxt;
         next     <= pc_nxt;
         oreg     <= oreg_nxt;
         oreg_wen <= wen_nxt;
      end
   end

   assign fault = (state == st_error);

endmodule

//--- logic/seq_system.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module seq_system (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    run,
   input  logic                    load_req,
   input  logic [`SEQ_ADDR_W-1:0]  load_addr,
   input  seq_pkg::seq_inst_t      load_word,
   output logic                    load_ack,
   input  logic [`SEQ_ADDR_W-1:0]  ext_in,
   output logic [`SEQ_ADDR_W-1:0]  port_out,
   output logic [`SEQ_ADDR_W-1:0]  pc,
   output seq_pkg::dev_cmd_t       cmd_bus,
   output logic [`SEQ_NUM_DEV-1:0] cmd_wen,
   output logic                    fault
);
   import seq_pkg::*;

   seq_inst_t              inst;
   logic [`SEQ_ADDR_W-1:0] count_0;
   logic [`SEQ_ADDR_W-1:0] count_1;
   logic [`SEQ_ADDR_W-1:0] sync_in;

   prog_mem mem0 (
      .clock     (clock),
      .reset     (reset),
      .addr      (pc),
      .inst      (inst),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_word (load_word),
      .load_ack  (load_ack)
   );

   seq_core core0 (
      .clock    (clock),
      .reset    (reset),
      .run      (run),
      .inst     (inst),
      .ireg_0   (count_0),
      .ireg_1   (count_1),
      .ireg_2   (sync_in),
      .ireg_3   (port_out),  // latch readback
      .next     (pc),
      .oreg     (cmd_bus),
      .oreg_wen (cmd_wen),
      .fault    (fault)
   );

   // device numbers 0 and 1
   counter_dev cnt0 (
      .clock  (clock),
      .reset  (reset),
      .cmd_en (cmd_wen[0]),
      .cmd    (cmd_bus),
      .count  (count_0)
   );

   counter_dev cnt1 (
      .clock  (clock),
      .reset  (reset),
      .cmd_en (cmd_wen[1]),
      .cmd    (cmd_bus),
      .count  (count_1)
   );

   // device 2, devices 3 to 7 have no listener
   io_dev io0 (
      .clock    (clock),
      .reset    (reset),
      .cmd_en   (cmd_wen[2]),
      .cmd      (cmd_bus),
      .ext_in   (ext_in),
      .sync_in  (sync_in),
      .port_out (port_out)
   );

endmodule

//--- verif/seq_props.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module seq_props (
   input logic                    clock,
   input logic                    reset,
   input logic [`SEQ_NUM_DEV-1:0] wen,
   input logic                    fault,
   input logic [`SEQ_ADDR_W-1:0]  next,
   input logic                    waiting,  // wait state, condition not yet met
   input logic                    load_req,
   input logic                    load_ack
);

   a_wen_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(wen))
      else $error("command wen is neither zero nor one-hot");

   // ack is raised on the edge that saw req high
   a_ack_rise: assert property (@(posedge clock) disable iff (reset)
      $rose(load_ack) |-> $past(load_req))
      else $error("load_ack rose without load_req");

   a_fault_sticky: assert property (@(posedge clock) $fell(fault) |-> $past(reset))
      else $error("fault dropped without reset");

   a_wait_hold: assert property (@(posedge clock) disable iff (reset)
      waiting |=> $stable(next))
      else $error("next moved during an unsatisfied wait");

endmodule

bind seq_core seq_props core_props (
   .clock    (clock),
   .reset    (reset),
   .wen      (oreg_wen),
   .fault    (fault),
   .next     (next),
   .waiting  (((state == seq_pkg::st_wait_z) && (src_val != '0)) ||
              ((state == seq_pkg::st_wait_n) && (src_val == '0))),
   .load_req (1'b0),
   .load_ack (1'b0)
);

bind prog_mem seq_props mem_props (
   .clock    (clock),
   .reset    (reset),
   .wen      ('0),
   .fault    (1'b0),
   .next     ('0),
   .waiting  (1'b0),
   .load_req (load_req),
   .load_ack (load_ack)
);

//--- verif/seq_tb.sv
`timescale 1ns/1ns
`include "seq_settings.svh"

module seq_tb;
   import seq_pkg::*;

   localparam int NUM_TESTS   = 6;
   localparam int PROG_WORDS  = 24;
   localparam int RUN_CYCLES  = 160;
   localparam int LOAD_CYCLES = 6;
   localparam int WATCHDOG_NS = (`SEQ_DEPTH * LOAD_CYCLES +
      NUM_TESTS * (PROG_WORDS * LOAD_CYCLES + RUN_CYCLES + 8) + 300) * 40;

   logic                    clock;
   logic                    reset;
   logic                    run;
   logic                    load_req;
   logic [`SEQ_ADDR_W-1:0]  load_addr;
   seq_inst_t               load_word;
   logic                    load_ack;
   logic [`SEQ_ADDR_W-1:0]  ext_in;
   logic [`SEQ_ADDR_W-1:0]  port_out;
   logic [`SEQ_ADDR_W-1:0]  pc;
   dev_cmd_t                cmd_bus;
   logic [`SEQ_NUM_DEV-1:0] cmd_wen;
   logic                    fault;

   seq_inst_t               prog [`SEQ_DEPTH];  // copy of what was loaded
   seq_state_e              m_state;
   logic [`SEQ_ADDR_W-1:0]  m_pc;
   logic [`SEQ_ADDR_W-1:0]  m_cnt0;
   logic [`SEQ_ADDR_W-1:0]  m_cnt1;
   logic [`SEQ_ADDR_W-1:0]  m_port;
   logic [`SEQ_ADDR_W-1:0]  m_sync1;
   logic [`SEQ_ADDR_W-1:0]  m_sync2;
   dev_cmd_t                m_cmd;  // pending command on the bus
   logic [`SEQ_NUM_DEV-1:0] m_wen;
   int                      seed = 86;
   int                      errors = 0;
   string                   test_name = "reset";

   seq_system dut0 (.*);

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   function automatic logic [7:0] apply_count(input logic [7:0] v, input dev_cmd_t c);
      case (c.cmd)
         cnt_clear: return 8'd0;
         cnt_load:  return c.arg;
         cnt_inc:   return v + 8'd1;
         cnt_dec:   return v - 8'd1;
         default:   return v;
      endcase
   endfunction

   function automatic logic [7:0] apply_io(input logic [7:0] v, input dev_cmd_t c);
      case (c.cmd)
         io_set:  return c.arg;
         io_and:  return v & c.arg;
         io_or:   return v | c.arg;
         io_xor:  return v ^ c.arg;
         default: return v;
      endcase
   endfunction

   // cycle model stepped on each rising edge
   always @(posedge clock) begin : model_step
      logic [7:0] c0;
      logic [7:0] c1;
      logic [7:0] s2;
      logic [7:0] pt;
      logic [7:0] sv;
      logic [7:0] label;
      seq_inst_t  ins;
      if (reset) begin
         m_state = st_reset;
         m_pc    = '0;
         m_cnt0  = '0;
         m_cnt1  = '0;
         m_port  = '0;
         m_sync1 = '0;
         m_sync2 = '0;
         m_cmd   = '0;
         m_wen   = '0;
      end else begin
         c0  = m_cnt0;
         c1  = m_cnt1;
         s2  = m_sync2;
         pt  = m_port;
         ins = prog[m_pc];
         if (m_wen[0]) m_cnt0 = apply_count(m_cnt0, m_cmd);
         if (m_wen[1]) m_cnt1 = apply_count(m_cnt1, m_cmd);
         if (m_wen[2]) m_port = apply_io(m_port, m_cmd);
         m_sync2 = m_sync1;
         m_sync1 = ext_in;
         case (ins.imm[1:0])
            2'd0:    sv = c0;
            2'd1:    sv = c1;
            2'd2:    sv = s2;
            default: sv = pt;
         endcase
         label = {ins.dev, ins.cmd};
         m_cmd = '0;
         m_wen = '0;
         case (m_state)
            st_reset: begin
               m_state = st_ready;
               m_pc    = '0;
            end
            st_ready: begin
               if (run) begin
                  case (ins.op)
                     op_no: m_pc = m_pc + 8'd1;
                     op_ci, op_cr: begin
                        m_cmd.cmd = ins.cmd;
                        m_cmd.arg = (ins.op == op_ci) ? ins.imm : sv;
                        m_wen     = 8'd1 << ins.dev[2:0];
                        m_pc      = m_pc + 8'd1;
                     end
                     op_ji: m_pc = label;
                     op_jr: m_pc = sv;
                     op_jz: m_pc = (sv == 8'd0) ? label : m_pc + 8'd1;
                     op_jn: m_pc = (sv != 8'd0) ? label : m_pc + 8'd1;
                     op_wz: begin
                        if (sv == 8'd0) m_pc = m_pc + 8'd1;
                        else m_state = st_wait_z;
                     end
                     op_wn: begin
                        if (sv != 8'd0) m_pc = m_pc + 8'd1;
                        else m_state = st_wait_n;
                     end
                     default: begin
                        m_state = st_error;
                        m_pc    = '0;
                     end
                  endcase
               end
            end
            st_wait_z: if (run && sv == 8'd0) begin
               m_state = st_ready;
               m_pc    = m_pc + 8'd1;
            end
            st_wait_n: if (run && sv != 8'd0) begin
               m_state = st_ready;
               m_pc    = m_pc + 8'd1;
            end
            default: m_pc = '0;
         endcase
      end
   end

   task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp) else begin
         errors++;
         $display("[FAIL] %s %s: expected %0h actual %0h", test_name, what, exp, act);
      end
   endtask

   always @(negedge clock) begin
      if (!reset) begin
         check_val("pc", {8'd0, m_pc}, {8'd0, pc});
         check_val("cmd_bus", {4'd0, m_cmd}, {4'd0, cmd_bus});
         check_val("cmd_wen", {8'd0, m_wen}, {8'd0, cmd_wen});
         check_val("port_out", {8'd0, m_port}, {8'd0, port_out});
         check_val("fault", {15'd0, m_state == st_error}, {15'd0, fault});
      end
   end

   // four-phase load of one word
   task automatic write_word(input logic [7:0] a, input seq_inst_t w);
      int waited;
      assert (load_ack == 1'b0) else begin
         errors++;
         $display("load_ack still high when a new transfer started at %0h", a);
      end
      load_addr = a;
      load_word = w;
      load_req  = 1'b1;
      prog[a]   = w;
      waited    = 0;
      while (load_ack !== 1'b1 && waited < 20) begin
         @(negedge clock);
         waited++;
      end
      assert (load_ack === 1'b1) else begin
         errors++;
         $display("load_ack never rose for address %0h", a);
      end
      @(posedge clock);
      #5 load_req = 1'b0;
      waited = 0;
      while (load_ack !== 1'b0 && waited < 20) begin
         @(negedge clock);
         waited++;
      end
      assert (load_ack === 1'b0) else begin
         errors++;
         $display("load_ack never fell for address %0h", a);
      end
      @(posedge clock);
      #5;
   endtask

   function automatic seq_inst_t gen_word(input int mode);
      seq_inst_t w;
      int        r;
      int        k;
      r     = $random(seed);
      k     = ($random(seed) & 32'h7fff_ffff) % 9;
      w.op  = op_no;
      w.dev = {1'b0, r[2:0]};
      w.cmd = {2'b00, r[5:4]};
      w.imm = r[15:8];
      case (mode)
         1: w.op = op_ci;
         2: begin
            w.op  = r[16] ? op_ci : op_cr;
            w.dev = (r[18:17] == 2'd3) ? 4'd2 : {2'b00, r[18:17]};  // counters or io
         end
         3: begin
            case (r[18:16])
               3'd0:    w.op = op_ci;
               3'd1:    w.op = op_ji;
               3'd2:    w.op = op_jr;
               3'd3:    w.op = op_jz;
               3'd4:    w.op = op_jn;
               default: w.op = op_no;
            endcase
            w.dev = {3'b000, r[20]};  // labels stay in the low 32 words
            w.cmd = r[24:21];
         end
         4: begin
            case (r[17:16])
               2'd0:    w.op = op_wz;
               2'd1:    w.op = op_wn;
               2'd2:    w.op = op_ci;
               default: w.op = op_no;
            endcase
            w.imm = {r[15:10], 2'b10};  // synchronised input
         end
         5: w.op = seq_op_e'(k[3:0]);
         default: w.op = op_no;
      endcase
      return w;
   endfunction

   task automatic apply_reset(input int cycles);
      reset = 1'b1;
      repeat (cycles) @(posedge clock);
      #5 reset = 1'b0;
   endtask

   task automatic run_test(input string name, input int mode);
      seq_inst_t w;
      int        r;
      test_name = name;
      run       = 1'b0;
      apply_reset(2);
      for (int i = 0; i < PROG_WORDS; i++) begin
         write_word(i[7:0], gen_word(mode));
      end
      if (mode == 6) begin
         r    = ($random(seed) & 32'h7fff_ffff) % 7;
         w    = gen_word(6);
         w.op = seq_op_e'(4'd9 + 4'(r));  // 9 to 15
         write_word(8'd3, w);
      end
      repeat (RUN_CYCLES) begin
         r   = $random(seed);
         run = (mode == 5) ? (r[2:0] != 3'd0) : 1'b1;
         if (r[5:3] == 3'd0)
            ext_in = (ext_in == 8'd0) ? (r[15:8] | 8'h01) : 8'h00;
         @(posedge clock);
         #5;
      end
      run = 1'b0;
      if (mode == 6) begin
         assert (fault === 1'b1 && pc === 8'd0) else begin
            errors++;
            $display("illegal opcode did not leave the core faulted at address 0");
         end
      end
   endtask

   initial begin
      seq_inst_t w;
      reset     = 1'b1;
      run       = 1'b0;
      load_req  = 1'b0;
      load_addr = '0;
      load_word = '0;
      ext_in    = '0;
      apply_reset(10);
      for (int a = 0; a < `SEQ_DEPTH; a++) begin
         w.op  = op_no;
         w.dev = a[3:0];
         w.cmd = a[7:4];
         w.imm = ~a[7:0];
         write_word(a[7:0], w);
      end
      run_test("load_ci", 1);
      run_test("devices", 2);
      run_test("jumps", 3);
      run_test("waits", 4);
      run_test("random", 5);
      run_test("illegal", 6);
      $display("checks done with %0d errors", errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- files.f
+incdir+include
logic/seq_pkg.sv
logic/prog_mem.sv
logic/counter_dev.sv
logic/io_dev.sv
logic/seq_core.sv
logic/seq_system.sv
verif/seq_props.sv
verif/seq_tb.sv

//--- run.sh
#!/bin/sh
# build and run the sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module seq_tb -o seq_sim &&
out=$(./obj_dir/seq_sim) || true
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
